//--- rtl/id_pkg.sv
// encodings shared by the two-slot alpha decode stage
// integer subset only; fp, misc and ftpi opcodes get no constants and decode as illegal
// enum values are binary from 0, so a cleared register reads addq and adder
package id_pkg;

	//////////////////////////////////////////////////
	// widths
	//////////////////////////////////////////////////
	localparam int xlen      = 64;  // datapath
	localparam int inst_w    = 32;
	localparam int reg_idx_w = 5;
	localparam logic [reg_idx_w-1:0] zero_reg = 5'd31; // r31, no writeback

	// instruction field positions
	localparam int op_msb       = 31;
	localparam int op_lsb       = 26;
	localparam int ra_msb       = 25;
	localparam int ra_lsb       = 21;
	localparam int rb_msb       = 20;
	localparam int rb_lsb       = 16;
	localparam int rc_msb       = 4;
	localparam int rc_lsb       = 0;
	localparam int func_msb     = 11;
	localparam int func_lsb     = 5;
	localparam int lit_flag     = 12; // operate format, literal in place of rb
	localparam int lit_msb      = 20;
	localparam int lit_lsb      = 13;
	localparam int mem_disp_msb = 15; // 16-bit signed
	localparam int br_disp_msb  = 20; // 21-bit signed, in words

	localparam logic [25:0] halt_code = 26'h0555; // call_pal function for halt

	//////////////////////////////////////////////////
	// opcodes
	//////////////////////////////////////////////////
	localparam logic [5:0] op_pal  = 6'h00;
	localparam logic [5:0] op_lda  = 6'h08;
	localparam logic [5:0] op_inta = 6'h10; // add, sub, compares
	localparam logic [5:0] op_intl = 6'h11; // logicals
	localparam logic [5:0] op_ints = 6'h12; // shifts
	localparam logic [5:0] op_intm = 6'h13; // multiply
	localparam logic [5:0] op_jsr  = 6'h1a; // jmp, jsr, ret, jsr_co
	localparam logic [5:0] op_ldq  = 6'h29;
	localparam logic [5:0] op_stq  = 6'h2d;
	localparam logic [5:0] op_br   = 6'h30;
	localparam logic [5:0] op_fbeq = 6'h31;
	localparam logic [5:0] op_fblt = 6'h32;
	localparam logic [5:0] op_fble = 6'h33;
	localparam logic [5:0] op_bsr  = 6'h34;
	localparam logic [5:0] op_fbne = 6'h35;
	localparam logic [5:0] op_fbge = 6'h36;
	localparam logic [5:0] op_fbgt = 6'h37;

	// function codes, bits 11:5
	localparam logic [6:0] fn_addq   = 7'h20;
	localparam logic [6:0] fn_subq   = 7'h29;
	localparam logic [6:0] fn_cmpeq  = 7'h2d;
	localparam logic [6:0] fn_cmpult = 7'h1d;
	localparam logic [6:0] fn_cmpule = 7'h3d;
	localparam logic [6:0] fn_cmplt  = 7'h4d;
	localparam logic [6:0] fn_cmple  = 7'h6d;
	localparam logic [6:0] fn_and    = 7'h00;
	localparam logic [6:0] fn_bic    = 7'h08;
	localparam logic [6:0] fn_bis    = 7'h20;
	localparam logic [6:0] fn_ornot  = 7'h28;
	localparam logic [6:0] fn_xor    = 7'h40;
	localparam logic [6:0] fn_eqv    = 7'h48;
	localparam logic [6:0] fn_srl    = 7'h34;
	localparam logic [6:0] fn_sll    = 7'h39;
	localparam logic [6:0] fn_sra    = 7'h3c;
	localparam logic [6:0] fn_mulq   = 7'h20; // same code as addq, other opcode

	//////////////////////////////////////////////////
	// select and function types
	//////////////////////////////////////////////////
	typedef enum logic [1:0] {opa_rega, opa_mem_disp, opa_npc, opa_not3} opa_sel_t;
	typedef enum logic [1:0] {opb_regb, opb_alu_imm, opb_br_disp} opb_sel_t;
	typedef enum logic [1:0] {dest_none, dest_rega, dest_regc} dest_sel_t;
	typedef enum logic [1:0] {fu_adder, fu_multiplier, fu_memory} fu_sel_t;

	typedef enum logic [4:0] {
		alu_addq, alu_subq, alu_cmpeq, alu_cmpult, alu_cmpule, alu_cmplt,
		alu_cmple, alu_and, alu_bic, alu_bis, alu_ornot, alu_xor, alu_eqv,
		alu_srl, alu_sll, alu_sra, alu_mulq
	} alu_func_t;

endpackage

//--- rtl/decode_ctrl_if.sv
// per-lane control from the decoder to the operand muxes
// purely combinational within a cycle, no handshake
interface decode_ctrl_if import id_pkg::*; ();

	opa_sel_t  opa_sel;  // operand a source
	opb_sel_t  opb_sel;  // operand b source
	dest_sel_t dest_sel; // writeback register field
	alu_func_t alu_func;

	// decoder side
	modport dec (
		output opa_sel,
		output opb_sel,
		output dest_sel,
		output alu_func
	);

	// operand selection side
	modport sel (
		input opa_sel,
		input opb_sel,
		input dest_sel,
		input alu_func
	);

endinterface

//--- rtl/inst_decoder.sv
// combinational decode of one alpha instruction into datapath control
// inst_valid low gives the no-op defaults; illegal instructions also keep the defaults
// halt counts as valid, only illegal clears valid
module inst_decoder import id_pkg::*; (
	input  logic [inst_w-1:0] inst,
	input  logic              inst_valid, // ignore inst when low
	decode_ctrl_if.dec        ctrl,
	output logic              rd_mem,
	output logic              wr_mem,
	output logic              cond_br,
	output logic              uncond_br,
	output logic              halt,
	output logic              illegal,
	output logic              valid
);

	logic [5:0] opcode;
	logic [6:0] func;
	logic       func_ok;  // function code known for this operate opcode
	alu_func_t  op_func;
	opa_sel_t   opa_sel;
	opb_sel_t   opb_sel;
	dest_sel_t  dest_sel;
	alu_func_t  alu_func;

	assign opcode = inst[op_msb:op_lsb];
	assign func   = inst[func_msb:func_lsb];

	//////////////////////////////////////////////////
	// operate format function lookup
	//////////////////////////////////////////////////
	always_comb begin
		op_func = alu_addq;
		func_ok = 1'b1;
		case (opcode)
			op_inta:
				case (func)
					fn_addq:   op_func = alu_addq;
					fn_subq:   op_func = alu_subq;
					fn_cmpeq:  op_func = alu_cmpeq;
					fn_cmpult: op_func = alu_cmpult;
					fn_cmpule: op_func = alu_cmpule;
					fn_cmplt:  op_func = alu_cmplt;
					fn_cmple:  op_func = alu_cmple;
					default:   func_ok = 1'b0;
				endcase
			op_intl:
				case (func)
					fn_and:   op_func = alu_and;
					fn_bic:   op_func = alu_bic;
					fn_bis:   op_func = alu_bis;
					fn_ornot: op_func = alu_ornot;
					fn_xor:   op_func = alu_xor;
					fn_eqv:   op_func = alu_eqv;
					default:  func_ok = 1'b0;
				endcase
			op_ints:
				case (func)
					fn_srl:  op_func = alu_srl;
					fn_sll:  op_func = alu_sll;
					fn_sra:  op_func = alu_sra;
					default: func_ok = 1'b0;
				endcase
			op_intm:
				if (func == fn_mulq)
					op_func = alu_mulq;
				else
					func_ok = 1'b0;
			default: func_ok = 1'b0; // not an operate opcode
		endcase
	end

	//////////////////////////////////////////////////
	// main decode by opcode
	//////////////////////////////////////////////////
	always_comb begin
		// no-op defaults
		opa_sel   = opa_rega;
		opb_sel   = opb_regb;
		alu_func  = alu_addq;
		dest_sel  = dest_none;
		rd_mem    = 1'b0;
		wr_mem    = 1'b0;
		cond_br   = 1'b0;
		uncond_br = 1'b0;
		halt      = 1'b0;
		illegal   = 1'b0;
		if (inst_valid) begin
			case (opcode)
				op_pal: begin
					if (inst[$bits(halt_code)-1:0] == halt_code)
						halt = 1'b1;
					else
						illegal = 1'b1; // other pal calls unsupported
				end
				op_inta, op_intl, op_ints, op_intm: begin
					if (func_ok) begin
						opb_sel  = inst[lit_flag] ? opb_alu_imm : opb_regb;
						alu_func = op_func;
						dest_sel = dest_regc;
					end else begin
						illegal = 1'b1;
					end
				end
				op_jsr: begin
					opa_sel   = opa_not3; // word-align rb target
					alu_func  = alu_and;
					dest_sel  = dest_rega; // return address
					uncond_br = 1'b1;
				end
				op_lda: begin
					opa_sel  = opa_mem_disp; // rb + disp into ra
					dest_sel = dest_rega;
				end
				op_ldq: begin
					opa_sel  = opa_mem_disp;
					dest_sel = dest_rega;
					rd_mem   = 1'b1;
				end
				op_stq: begin
					opa_sel = opa_mem_disp; // ra is store data, no writeback
					wr_mem  = 1'b1;
				end
				op_br, op_bsr: begin
					opa_sel   = opa_npc;
					opb_sel   = opb_br_disp;
					dest_sel  = dest_rega; // link register
					uncond_br = 1'b1;
				end
				op_fbeq, op_fblt, op_fble, op_fbne, op_fbge, op_fbgt:
					illegal = 1'b1; // no fp branches
				default: begin
					if (opcode[5:4] == 2'b11) begin // integer conditional branches
						opa_sel = opa_npc;
						opb_sel = opb_br_disp;
						cond_br = 1'b1;
					end else begin
						illegal = 1'b1; // fp, misc, ftpi and unused opcodes
					end
				end
			endcase
		end
	end

	assign valid = inst_valid & ~illegal;

	assign ctrl.opa_sel  = opa_sel;
	assign ctrl.opb_sel  = opb_sel;
	assign ctrl.dest_sel = dest_sel;
	assign ctrl.alu_func = alu_func;

endmodule

//--- rtl/operand_select.sv
// immediate extraction and operand, destination and unit muxes for one lane
// a register operand comes out as its zero-extended index with is_value low
// fu_sel looks at the raw opcode, it does not depend on inst_valid
module operand_select import id_pkg::*; (
	input  logic [inst_w-1:0]    inst,
	input  logic [xlen-1:0]      npc,   // pc + 4 of this inst
	decode_ctrl_if.sel           ctrl,
	output logic [xlen-1:0]      opa,
	output logic                 opa_is_value,
	output logic [xlen-1:0]      opb,
	output logic                 opb_is_value,
	output logic [reg_idx_w-1:0] dest_idx,
	output alu_func_t            alu_func,
	output fu_sel_t              fu_sel
);

	localparam int lit_w = lit_msb - lit_lsb + 1;

	logic [reg_idx_w-1:0] ra_idx;
	logic [reg_idx_w-1:0] rb_idx;
	logic [reg_idx_w-1:0] rc_idx;
	logic [xlen-1:0]      mem_disp;
	logic [xlen-1:0]      br_disp;
	logic [xlen-1:0]      alu_imm;
	logic [2:0]           op_grp;   // top opcode bits

	assign ra_idx = inst[ra_msb:ra_lsb];
	assign rb_idx = inst[rb_msb:rb_lsb];
	assign rc_idx = inst[rc_msb:rc_lsb];
	assign op_grp = inst[op_msb -: 3];

	// immediates
	assign mem_disp = {{(xlen-mem_disp_msb-1){inst[mem_disp_msb]}}, inst[mem_disp_msb:0]};
	assign br_disp  = {{(xlen-br_disp_msb-3){inst[br_disp_msb]}}, inst[br_disp_msb:0], 2'b00};
	assign alu_imm  = {{(xlen-lit_w){1'b0}}, inst[lit_msb:lit_lsb]}; // literal is unsigned

	//////////////////////////////////////////////////
	// operand muxes
	//////////////////////////////////////////////////
	always_comb begin
		opa_is_value = 1'b1;
		case (ctrl.opa_sel)
			opa_rega: begin
				opa          = {{(xlen-reg_idx_w){1'b0}}, ra_idx};
				opa_is_value = 1'b0; // tag, read regfile later
			end
			opa_mem_disp: opa = mem_disp;
			opa_npc:      opa = npc;
			default:      opa = ~{{(xlen-2){1'b0}}, 2'b11}; // not3 mask
		endcase
	end

	always_comb begin
		opb_is_value = 1'b1;
		case (ctrl.opb_sel)
			opb_alu_imm: opb = alu_imm;
			opb_br_disp: opb = br_disp;
			default: begin // regb
				opb          = {{(xlen-reg_idx_w){1'b0}}, rb_idx};
				opb_is_value = 1'b0;
			end
		endcase
	end

	// writeback index, r31 when none
	always_comb begin
		case (ctrl.dest_sel)
			dest_regc: dest_idx = rc_idx;
			dest_rega: dest_idx = ra_idx;
			default:   dest_idx = zero_reg;
		endcase
	end

	// unit select: lda/ldah, loads and stores go to memory
	always_comb begin
		case (op_grp)
			3'b001, 3'b100, 3'b101: fu_sel = fu_memory;
			default:                fu_sel = (ctrl.alu_func == alu_mulq) ? fu_multiplier : fu_adder;
		endcase
	end

	assign alu_func = ctrl.alu_func;

endmodule

//--- rtl/decode_slot.sv
// one decode lane: decoder, operand muxes and the output register
// one cycle latency; stall high holds every output and drops the current input
module decode_slot import id_pkg::*; (
	input  logic                 clock,
	input  logic                 rst_n,
	input  logic                 stall,
	input  logic [inst_w-1:0]    inst,
	input  logic                 inst_valid,
	input  logic [xlen-1:0]      npc,
	output logic [xlen-1:0]      opa,
	output logic                 opa_is_value,
	output logic [xlen-1:0]      opb,
	output logic                 opb_is_value,
	output logic [reg_idx_w-1:0] dest_idx,
	output alu_func_t            alu_func,
	output logic [5:0]           op_type,   // opcode field
	output fu_sel_t              fu_sel,
	output logic                 rd_mem,
	output logic                 wr_mem,
	output logic                 cond_br,
	output logic                 uncond_br,
	output logic                 halt,
	output logic                 illegal,
	output logic                 valid
);

	// combinational lane results
	logic [xlen-1:0]      d_opa;
	logic [xlen-1:0]      d_opb;
	logic                 d_opa_is_value;
	logic                 d_opb_is_value;
	logic [reg_idx_w-1:0] d_dest_idx;
	alu_func_t            d_alu_func;
	fu_sel_t              d_fu_sel;
	logic                 d_rd_mem;
	logic                 d_wr_mem;
	logic                 d_cond_br;
	logic                 d_uncond_br;
	logic                 d_halt;
	logic                 d_illegal;
	logic                 d_valid;

	decode_ctrl_if u_ctrl ();

	inst_decoder u_dec (
		.inst(inst), .inst_valid(inst_valid), .ctrl(u_ctrl.dec),
		.rd_mem(d_rd_mem), .wr_mem(d_wr_mem),
		.cond_br(d_cond_br), .uncond_br(d_uncond_br),
		.halt(d_halt), .illegal(d_illegal), .valid(d_valid)
	);

	operand_select u_sel (
		.inst(inst), .npc(npc), .ctrl(u_ctrl.sel),
		.opa(d_opa), .opa_is_value(d_opa_is_value),
		.opb(d_opb), .opb_is_value(d_opb_is_value),
		.dest_idx(d_dest_idx), .alu_func(d_alu_func), .fu_sel(d_fu_sel)
	);

	//////////////////////////////////////////////////
	// decode output register
	//////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			opa          <= '0;
			opa_is_value <= 1'b0;
			opb          <= '0;
			opb_is_value <= 1'b0;
			dest_idx     <= zero_reg; // no writeback out of reset
			alu_func     <= alu_addq;
			op_type      <= '0;
			fu_sel       <= fu_adder;
			rd_mem       <= 1'b0;
			wr_mem       <= 1'b0;
			cond_br      <= 1'b0;
			uncond_br    <= 1'b0;
			halt         <= 1'b0;
			illegal      <= 1'b0;
			valid        <= 1'b0;
		end else if (!stall) begin // hold while stalled
			opa          <= d_opa;
			opa_is_value <= d_opa_is_value;
			opb          <= d_opb;
			opb_is_value <= d_opb_is_value;
			dest_idx     <= d_dest_idx;
			alu_func     <= d_alu_func;
			op_type      <= inst[op_msb:op_lsb];
			fu_sel       <= d_fu_sel;
			rd_mem       <= d_rd_mem;
			wr_mem       <= d_wr_mem;
			cond_br      <= d_cond_br;
			uncond_br    <= d_uncond_br;
			halt         <= d_halt;
			illegal      <= d_illegal;
			valid        <= d_valid;
		end
	end

endmodule

//--- rtl/id_stage.sv
// two-slot decode stage, lanes are independent with no cross-lane checks
// both lanes share one stall, outputs follow the capturing edge by one cycle
module id_stage import id_pkg::*; (
	input  logic                 clock,
	input  logic                 rst_n,
	input  logic                 stall,   // hold both lanes
	input  logic [inst_w-1:0]    inst1,
	input  logic [inst_w-1:0]    inst2,
	input  logic                 inst_valid1,
	input  logic                 inst_valid2,
	input  logic [xlen-1:0]      npc1,
	input  logic [xlen-1:0]      npc2,

	// lane 1
	output logic [xlen-1:0]      opa_1, opb_1,
	output logic                 opa_is_value_1, opb_is_value_1,
	output logic [reg_idx_w-1:0] dest_idx_1,
	output alu_func_t            alu_func_1,
	output logic [5:0]           op_type_1,
	output fu_sel_t              fu_sel_1,
	output logic                 rd_mem_1, wr_mem_1, cond_br_1, uncond_br_1,
	output logic                 halt_1, illegal_1, valid_1,

	// lane 2
	output logic [xlen-1:0]      opa_2, opb_2,
	output logic                 opa_is_value_2, opb_is_value_2,
	output logic [reg_idx_w-1:0] dest_idx_2,
	output alu_func_t            alu_func_2,
	output logic [5:0]           op_type_2,
	output fu_sel_t              fu_sel_2,
	output logic                 rd_mem_2, wr_mem_2, cond_br_2, uncond_br_2,
	output logic                 halt_2, illegal_2, valid_2
);

	//////////////////////////////////////////////////
	// lanes
	//////////////////////////////////////////////////
	decode_slot u_slot1 (
		.clock(clock), .rst_n(rst_n), .stall(stall),
		.inst(inst1), .inst_valid(inst_valid1), .npc(npc1),
		.opa(opa_1), .opa_is_value(opa_is_value_1),
		.opb(opb_1), .opb_is_value(opb_is_value_1),
		.dest_idx(dest_idx_1), .alu_func(alu_func_1),
		.op_type(op_type_1), .fu_sel(fu_sel_1),
		.rd_mem(rd_mem_1), .wr_mem(wr_mem_1),
		.cond_br(cond_br_1), .uncond_br(uncond_br_1),
		.halt(halt_1), .illegal(illegal_1), .valid(valid_1)
	);

	decode_slot u_slot2 ( // older-second slot, same decode
		.clock(clock), .rst_n(rst_n), .stall(stall),
		.inst(inst2), .inst_valid(inst_valid2), .npc(npc2),
		.opa(opa_2), .opa_is_value(opa_is_value_2),
		.opb(opb_2), .opb_is_value(opb_is_value_2),
		.dest_idx(dest_idx_2), .alu_func(alu_func_2),
		.op_type(op_type_2), .fu_sel(fu_sel_2),
		.rd_mem(rd_mem_2), .wr_mem(wr_mem_2),
		.cond_br(cond_br_2), .uncond_br(uncond_br_2),
		.halt(halt_2), .illegal(illegal_2), .valid(valid_2)
	);

endmodule

//--- dv/id_stage_props.sv
// concurrent checks on the registered outputs of id_stage, attached by bind
// hold rule needs a non-reset previous edge
module id_stage_props import id_pkg::*; (
	input logic                 clock,
	input logic                 rst_n,
	input logic                 stall,
	input logic [xlen-1:0]      opa_1, opb_1, opa_2, opb_2,
	input logic                 opa_is_value_1, opb_is_value_1,
	input logic                 opa_is_value_2, opb_is_value_2,
	input logic [reg_idx_w-1:0] dest_idx_1, dest_idx_2,
	input alu_func_t            alu_func_1, alu_func_2,
	input logic [5:0]           op_type_1, op_type_2,
	input fu_sel_t              fu_sel_1, fu_sel_2,
	input logic                 rd_mem_1, wr_mem_1, cond_br_1, uncond_br_1, halt_1, illegal_1, valid_1,
	input logic                 rd_mem_2, wr_mem_2, cond_br_2, uncond_br_2, halt_2, illegal_2, valid_2
);
	timeunit 1ns;
	timeprecision 100ps;

	logic [154:0] lane1_q; // whole lane bundle
	logic [154:0] lane2_q;

	assign lane1_q = {opa_1, opa_is_value_1, opb_1, opb_is_value_1, dest_idx_1, alu_func_1,
		op_type_1, fu_sel_1, rd_mem_1, wr_mem_1, cond_br_1, uncond_br_1, halt_1, illegal_1, valid_1};
	assign lane2_q = {opa_2, opa_is_value_2, opb_2, opb_is_value_2, dest_idx_2, alu_func_2,
		op_type_2, fu_sel_2, rd_mem_2, wr_mem_2, cond_br_2, uncond_br_2, halt_2, illegal_2, valid_2};

	a_valid_legal: assert property (@(posedge clock) disable iff (!rst_n)
		!(valid_1 && illegal_1) && !(valid_2 && illegal_2))
		else $error("valid set together with illegal");
	a_mem_excl: assert property (@(posedge clock) disable iff (!rst_n)
		!(rd_mem_1 && wr_mem_1) && !(rd_mem_2 && wr_mem_2))
		else $error("load and store flags both set");
	a_br_excl: assert property (@(posedge clock) disable iff (!rst_n)
		!(cond_br_1 && uncond_br_1) && !(cond_br_2 && uncond_br_2))
		else $error("conditional and unconditional branch both set");
	// stall on the previous edge freezes both lanes
	a_stall_hold: assert property (@(posedge clock) disable iff (!rst_n)
		($past(stall) && $past(rst_n)) |-> (lane1_q == $past(lane1_q) && lane2_q == $past(lane2_q)))
		else $error("decode outputs changed across a stalled edge");

endmodule

bind id_stage id_stage_props u_props (.*);

//--- dv/id_stage_tb.sv
// testbench for the two-slot decode stage
// inputs change 1 ns after the rising edge and outputs are checked on the falling edge
// expected lane = reference decode of the last edge with stall low
module id_stage_tb import id_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int n_dir      = 35;   // directed vectors incl. final idle
	localparam int n_stall_ph = 200;  // stall pulse phase and bound on stall cycles
	localparam int n_rand     = 2000;
	localparam int timeout_ns = (n_dir + n_stall_ph + n_rand + n_stall_ph + 20) * 4;

	typedef struct packed {
		logic [63:0] opa;
		logic        opa_v;
		logic [63:0] opb;
		logic        opb_v;
		logic [4:0]  dest;
		logic [4:0]  alu;
		logic [5:0]  op_type;
		logic [1:0]  fu;
		logic        rd_mem, wr_mem, cond_br, uncond_br, halt, illegal, valid;
	} lane_t;

	logic        clock, rst_n, stall;
	logic [31:0] inst1, inst2;
	logic        inst_valid1, inst_valid2;
	logic [63:0] npc1, npc2;
	logic [63:0] opa_1, opb_1, opa_2, opb_2;
	logic        opa_is_value_1, opb_is_value_1, opa_is_value_2, opb_is_value_2;
	logic [4:0]  dest_idx_1, dest_idx_2;
	alu_func_t   alu_func_1, alu_func_2;
	logic [5:0]  op_type_1, op_type_2;
	fu_sel_t     fu_sel_1, fu_sel_2;
	logic        rd_mem_1, wr_mem_1, cond_br_1, uncond_br_1, halt_1, illegal_1, valid_1;
	logic        rd_mem_2, wr_mem_2, cond_br_2, uncond_br_2, halt_2, illegal_2, valid_2;

	integer      seed;
	int          errors, checks, k;
	logic [63:0] npc_next;
	lane_t       exp1, exp2, act1, act2;

	id_stage u_dut (.*);

	always #2 clock = ~clock; // 4 ns period

	//////////////////////////////////////////////////
	// encodings and reference decode
	//////////////////////////////////////////////////
	// {opcode, function, alu op} of every integer operate instruction
	function automatic logic [17:0] op_entry(input int i);
		case (i)
			0:       return {op_inta, fn_addq, alu_addq};
			1:       return {op_inta, fn_subq, alu_subq};
			2:       return {op_inta, fn_cmpeq, alu_cmpeq};
			3:       return {op_inta, fn_cmpult, alu_cmpult};
			4:       return {op_inta, fn_cmpule, alu_cmpule};
			5:       return {op_inta, fn_cmplt, alu_cmplt};
			6:       return {op_inta, fn_cmple, alu_cmple};
			7:       return {op_intl, fn_and, alu_and};
			8:       return {op_intl, fn_bic, alu_bic};
			9:       return {op_intl, fn_bis, alu_bis};
			10:      return {op_intl, fn_ornot, alu_ornot};
			11:      return {op_intl, fn_xor, alu_xor};
			12:      return {op_intl, fn_eqv, alu_eqv};
			13:      return {op_ints, fn_srl, alu_srl};
			14:      return {op_ints, fn_sll, alu_sll};
			15:      return {op_ints, fn_sra, alu_sra};
			16:      return {op_intm, fn_mulq, alu_mulq};
			default: return '0;
		endcase
	endfunction

	function automatic logic [31:0] opr_inst(input logic [5:0] op, input logic [4:0] ra,
		input logic [4:0] rb, input logic [6:0] fn, input logic [4:0] rc);
		return {op, ra, rb, 3'b000, 1'b0, fn, rc};
	endfunction

	function automatic logic [31:0] lit_inst(input logic [5:0] op, input logic [4:0] ra,
		input logic [7:0] lit, input logic [6:0] fn, input logic [4:0] rc);
		return {op, ra, lit, 1'b1, fn, rc};
	endfunction

	function automatic logic [31:0] mem_inst(input logic [5:0] op, input logic [4:0] ra,
		input logic [4:0] rb, input logic [15:0] disp);
		return {op, ra, rb, disp};
	endfunction

	function automatic logic [31:0] br_inst(input logic [5:0] op, input logic [4:0] ra,
		input logic [20:0] disp);
		return {op, ra, disp};
	endfunction

	function automatic lane_t reset_lane();
		lane_t e;
		e      = '0;
		e.dest = zero_reg; // no writeback
		return e;
	endfunction

	function automatic lane_t ref_decode(input logic [31:0] inst, input logic v,
		input logic [63:0] npc);
		lane_t       e;
		logic [5:0]  op;
		logic [17:0] ent;
		logic        ok;
		op        = inst[31:26];
		e         = '0;
		e.opa     = {59'd0, inst[25:21]}; // register tags by default
		e.opb     = {59'd0, inst[20:16]};
		e.dest    = zero_reg;
		e.alu     = alu_addq;
		e.op_type = op;
		ok        = 1'b0;
		if (v) begin
			if (op inside {op_inta, op_intl, op_ints, op_intm}) begin
				for (int i = 0; i < 17; i++) begin
					ent = op_entry(i);
					if (ent[17:12] == op && ent[11:5] == inst[11:5]) begin
						ok    = 1'b1;
						e.alu = ent[4:0];
					end
				end
				if (ok) begin
					e.dest = inst[4:0];
					if (inst[12]) begin // literal form
						e.opb   = {56'd0, inst[20:13]};
						e.opb_v = 1'b1;
					end
				end else begin
					e.illegal = 1'b1;
				end
			end else begin
				case (op)
					op_pal: begin
						if (inst[25:0] == halt_code)
							e.halt = 1'b1;
						else
							e.illegal = 1'b1;
					end
					op_jsr: begin
						e.opa       = ~64'd3; // word-align mask
						e.opa_v     = 1'b1;
						e.alu       = alu_and;
						e.dest      = inst[25:21];
						e.uncond_br = 1'b1;
					end
					op_lda, op_ldq, op_stq: begin
						e.opa    = {{48{inst[15]}}, inst[15:0]};
						e.opa_v  = 1'b1;
						e.rd_mem = (op == op_ldq);
						e.wr_mem = (op == op_stq);
						if (op != op_stq)
							e.dest = inst[25:21];
					end
					op_br, op_bsr: begin
						e.opa       = npc;
						e.opa_v     = 1'b1;
						e.opb       = {{41{inst[20]}}, inst[20:0], 2'b00};
						e.opb_v     = 1'b1;
						e.dest      = inst[25:21]; // link
						e.uncond_br = 1'b1;
					end
					default: begin
						if (op[5:3] == 3'b111) begin // beq .. bgt, blbc, blbs
							e.opa     = npc;
							e.opa_v   = 1'b1;
							e.opb     = {{41{inst[20]}}, inst[20:0], 2'b00};
							e.opb_v   = 1'b1;
							e.cond_br = 1'b1;
						end else begin
							e.illegal = 1'b1; // fp branches, fp, misc, ftpi
						end
					end
				endcase
			end
		end
		// unit from the raw opcode even for invalid slots
		if (op[5:3] inside {3'b001, 3'b100, 3'b101})
			e.fu = fu_memory;
		else if (e.alu == alu_mulq)
			e.fu = fu_multiplier;
		else
			e.fu = fu_adder;
		e.valid = v & ~e.illegal;
		return e;
	endfunction

	// biased toward implemented opcodes
	function automatic logic [31:0] rand_inst();
		logic [31:0] r;
		logic [3:0]  sel;
		logic [17:0] ent;
		r   = $random(seed);
		sel = $random(seed);
		ent = op_entry($unsigned(r) % 17);
		case (sel)
			0, 1, 2, 3: return {ent[17:12], r[25:12], ent[11:5], r[4:0]};
			4:          return {ent[17:12], r[25:0]}; // mostly bad function codes
			5:          return {op_jsr, r[25:0]};
			6:          return {op_lda, r[25:0]};
			7:          return {op_ldq, r[25:0]};
			8:          return {op_stq, r[25:0]};
			9:          return {r[31] ? op_br : op_bsr, r[25:0]};
			10, 11:     return {3'b111, r[28:0]};
			12:         return {op_pal, r[31] ? halt_code : r[25:0]};
			default:    return r;
		endcase
	endfunction

	//////////////////////////////////////////////////
	// stimulus and checking
	//////////////////////////////////////////////////
	task automatic drive(input logic [31:0] i1, input logic v1, input logic [31:0] i2,
		input logic v2, input logic st);
		@(posedge clock);
		#1;
		inst1       = i1;
		inst_valid1 = v1;
		inst2       = i2;
		inst_valid2 = v2;
		npc1        = npc_next;
		npc2        = npc_next + 64'd4;
		npc_next    = npc_next + 64'd8;
		stall       = st;
	endtask

	task automatic check_field(input string name, input logic [63:0] exp, input logic [63:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %s expected %h got %h at %0t", name, exp, act, $time);
		end
	endtask

	task automatic check_lane(input int n, input lane_t e, input lane_t a);
		check_field($sformatf("opa_%0d", n), e.opa, a.opa);
		check_field($sformatf("opa_is_value_%0d", n), e.opa_v, a.opa_v);
		check_field($sformatf("opb_%0d", n), e.opb, a.opb);
		check_field($sformatf("opb_is_value_%0d", n), e.opb_v, a.opb_v);
		check_field($sformatf("dest_idx_%0d", n), e.dest, a.dest);
		check_field($sformatf("alu_func_%0d", n), e.alu, a.alu);
		check_field($sformatf("op_type_%0d", n), e.op_type, a.op_type);
		check_field($sformatf("fu_sel_%0d", n), e.fu, a.fu);
		check_field($sformatf("rd_mem_%0d", n), e.rd_mem, a.rd_mem);
		check_field($sformatf("wr_mem_%0d", n), e.wr_mem, a.wr_mem);
		check_field($sformatf("cond_br_%0d", n), e.cond_br, a.cond_br);
		check_field($sformatf("uncond_br_%0d", n), e.uncond_br, a.uncond_br);
		check_field($sformatf("halt_%0d", n), e.halt, a.halt);
		check_field($sformatf("illegal_%0d", n), e.illegal, a.illegal);
		check_field($sformatf("valid_%0d", n), e.valid, a.valid);
	endtask

	// compare process with one cycle latency
	initial begin
		forever begin
			@(posedge clock);
			if (!rst_n) begin
				exp1 = reset_lane();
				exp2 = reset_lane();
			end else if (!stall) begin // stalled edge keeps the old bundle
				exp1 = ref_decode(inst1, inst_valid1, npc1);
				exp2 = ref_decode(inst2, inst_valid2, npc2);
			end
			@(negedge clock);
			act1 = {opa_1, opa_is_value_1, opb_1, opb_is_value_1, dest_idx_1, alu_func_1,
				op_type_1, fu_sel_1, rd_mem_1, wr_mem_1, cond_br_1, uncond_br_1, halt_1,
				illegal_1, valid_1};
			act2 = {opa_2, opa_is_value_2, opb_2, opb_is_value_2, dest_idx_2, alu_func_2,
				op_type_2, fu_sel_2, rd_mem_2, wr_mem_2, cond_br_2, uncond_br_2, halt_2,
				illegal_2, valid_2};
			check_lane(1, exp1, act1);
			check_lane(2, exp2, act2);
		end
	end

	// watchdog
	initial begin
		#(timeout_ns);
		$display("timeout: the tests did not finish within %0d ns", timeout_ns);
		$display("Something failed");
		$finish;
	end

	initial begin
		seed        = 32'h82e7274a;
		errors      = 0;
		checks      = 0;
		clock       = 1'b0;
		rst_n       = 1'b0;
		stall       = 1'b0;
		inst1       = '0;
		inst2       = '0;
		inst_valid1 = 1'b0;
		inst_valid2 = 1'b0;
		npc1        = '0;
		npc2        = '0;
		npc_next    = 64'hfedc_ba98_0000_1000; // high bits exercise the full npc width
		repeat (2) @(posedge clock);
		#1 rst_n = 1'b1;

		// operate ops in register form on lane 1 and literal form on lane 2
		for (k = 0; k < 17; k++)
			drive(opr_inst(op_entry(k) >> 12, 5'(k), 5'(30 - k), op_entry(k) >> 5, 5'(k + 3)),
				1'b1, lit_inst(op_entry(k) >> 12, 5'(k + 1), 8'(k * 15 + 7), op_entry(k) >> 5,
				5'(29 - k)), 1'b1, 1'b0);

		// memory and control
		drive(mem_inst(op_lda, 5'd1, 5'd2, 16'h7ff0), 1'b1,
			mem_inst(op_lda, 5'd3, 5'd4, 16'h8004), 1'b1, 1'b0);
		drive(mem_inst(op_ldq, 5'd5, 5'd6, 16'h0010), 1'b1,
			mem_inst(op_stq, 5'd7, 5'd8, 16'hfff8), 1'b1, 1'b0);
		drive(br_inst(op_br, 5'd26, 21'h0fffff), 1'b1,
			br_inst(op_bsr, 5'd26, 21'h100000), 1'b1, 1'b0);
		for (k = 0; k < 4; k++) // 0x38 .. 0x3f
			drive(br_inst(6'h38 + 6'(2 * k), 5'(k), 21'h1fffff - 21'(k)), 1'b1,
				br_inst(6'h39 + 6'(2 * k), 5'(k + 1), 21'h000040 + 21'(k)), 1'b1, 1'b0);
		drive(mem_inst(op_jsr, 5'd26, 5'd27, 16'h4000), 1'b1,
			mem_inst(op_jsr, 5'd31, 5'd1, 16'hc000), 1'b1, 1'b0);

		// illegal, halt and invalid slots
		drive(opr_inst(op_inta, 5'd1, 5'd2, 7'h7f, 5'd3), 1'b1,
			opr_inst(op_intl, 5'd4, 5'd5, 7'h01, 5'd6), 1'b1, 1'b0);
		drive(opr_inst(op_ints, 5'd7, 5'd8, 7'h00, 5'd9), 1'b1,
			lit_inst(op_intm, 5'd10, 8'h55, 7'h21, 5'd11), 1'b1, 1'b0);
		drive({6'h14, 26'h123_4567}, 1'b1, {6'h16, 26'h0ab_cdef}, 1'b1, 1'b0); // fp groups
		drive({6'h18, 26'h000_4000}, 1'b1, {6'h1c, 26'h3ff_ffff}, 1'b1, 1'b0); // misc, ftpi
		drive(br_inst(op_fbeq, 5'd1, 21'h10), 1'b1, br_inst(op_fblt, 5'd2, 21'h20), 1'b1, 1'b0);
		drive(br_inst(op_fble, 5'd3, 21'h30), 1'b1, br_inst(op_fbne, 5'd4, 21'h40), 1'b1, 1'b0);
		drive(br_inst(op_fbge, 5'd5, 21'h50), 1'b1, br_inst(op_fbgt, 5'd6, 21'h60), 1'b1, 1'b0);
		drive({op_pal, 26'h000_0000}, 1'b1, {op_pal, halt_code}, 1'b1, 1'b0);
		drive(opr_inst(op_inta, 5'd1, 5'd2, fn_addq, 5'd3), 1'b0,
			mem_inst(op_ldq, 5'd4, 5'd5, 16'h0008), 1'b0, 1'b0);

		// random stall pulses drop the stalled inputs
		for (k = 0; k < n_stall_ph; k++)
			drive(rand_inst(), 1'b1, rand_inst(), 1'b1, ($random(seed) & 3) == 0);

		// random mix without stall
		for (k = 0; k < n_rand; k++)
			drive(rand_inst(), ($random(seed) & 15) != 0, rand_inst(),
				($random(seed) & 15) != 0, 1'b0);

		drive('0, 1'b0, '0, 1'b0, 1'b0);
		repeat (2) @(negedge clock);
		#1; // last compare done

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

//--- src.f
rtl/id_pkg.sv
rtl/decode_ctrl_if.sv
rtl/inst_decoder.sv
rtl/operand_select.sv
rtl/decode_slot.sv
rtl/id_stage.sv
dv/id_stage_props.sv
dv/id_stage_tb.sv
